// File: filelist.f
rtl/cpuPkg.sv
rtl/memPkg.sv
rtl/memIfs.sv
rtl/rvCore.sv
rtl/l1Cache.sv
rtl/memArbiter.sv
rtl/rvSystem.sv
verif/rvSystem_sva.sv
verif/rvSystemTb.sv

// File: run.sh
#!/bin/sh
# build and run the rvSystem testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert --top-module rvSystemTb -f filelist.f -o rvSystemSim

./obj_dir/rvSystemSim | tee sim.log

# the run passes only when the pass line is in the log
grep -qx "ALL CHECKS PASSED" sim.log
echo "simulation passed"

// File: verif/rvSystemTb.sv
`default_nettype none

module rvSystemTb;
	import cpuPkg::*;
	import memPkg::*;

	localparam int RUN_TIMEOUT = 5000;
	localparam int MODEL_STEPS = 4000;

	logic clk_mem;
	logic rst;
	logic enable_i;
	logic [31:0] bootPc_i;
	logic [31:0] memRData_i;
	logic memReady_i;
	logic memRead_o;
	logic memWrite_o;
	logic [31:0] memAddr_o;
	logic [31:0] memWData_o;
	logic l1iMiss_o;
	logic l1dMiss_o;

	logic [31:0] mem [logic [31:0]];
	logic [31:0] refMem [logic [31:0]];
	logic [31:0] expAddr [$];
	logic [31:0] expData [$];
	logic [31:0] tagStore [2][LINES_DEF];
	logic tagValid [2][LINES_DEF];
	logic [31:0] lfsrState = 32'h6125c0ee;
	int expIMiss;
	int expDMiss;
	int storeIdx;
	int iMissCnt;
	int dMissCnt;
	int mismatches = 0;
	int failures = 0;

	rvSystem #(
		.lineWords (LINE_WORDS_DEF),
		.lines     (LINES_DEF)
	) rvSystem_i (
		.clk_mem    (clk_mem),
		.rst        (rst),
		.enable_i   (enable_i),
		.bootPc_i   (bootPc_i),
		.memRData_i (memRData_i),
		.memReady_i (memReady_i),
		.memRead_o  (memRead_o),
		.memWrite_o (memWrite_o),
		.memAddr_o  (memAddr_o),
		.memWData_o (memWData_o),
		.l1iMiss_o  (l1iMiss_o),
		.l1dMiss_o  (l1dMiss_o)
	);

	initial begin
		clk_mem = 1'b0;
		forever #20 clk_mem = ~clk_mem;
	end

	task automatic checkValue(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			mismatches++;
			$display("mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
		end
	endtask

	// galois lfsr, x^32 + x^22 + x^2 + x + 1
	function automatic logic nextRandomBit();
		logic outBit;
		outBit = lfsrState[0];
		lfsrState = lfsrState >> 1;
		if (outBit) begin
			lfsrState = lfsrState ^ 32'h80200003;
		end
		return outBit;
	endfunction

	function automatic int drawDelay();
		int delay;
		delay = 0;
		for (int i = 0; i < 3; i++) begin
			delay = delay * 2 + (nextRandomBit() ? 1 : 0);
		end
		return delay;
	endfunction

	// unwritten words read back a value tied to the full address
	function automatic logic [31:0] fillWord(input logic [31:0] addr);
		return {addr[15:0], addr[31:16]} ^ 32'h3c5aa5c3;
	endfunction

	function automatic logic [31:0] refRead(input logic [31:0] addr);
		return refMem.exists(addr) ? refMem[addr] : fillWord(addr);
	endfunction

	// instruction encoders
	function automatic logic [31:0] luiInstr(input int rd, input int imm);
		return {imm[19:0], rd[4:0], OPC_LUI};
	endfunction

	function automatic logic [31:0] addiInstr(input int rd, input int rs1, input int imm);
		return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP_IMM};
	endfunction

	function automatic logic [31:0] arithInstr(input logic isSub, input int rd, input int rs1,
			input int rs2);
		return {isSub ? 7'b0100000 : 7'b0000000, rs2[4:0], rs1[4:0], 3'b000, rd[4:0], OPC_OP};
	endfunction

	function automatic logic [31:0] lwInstr(input int rd, input int rs1, input int off);
		return {off[11:0], rs1[4:0], 3'b010, rd[4:0], OPC_LOAD};
	endfunction

	function automatic logic [31:0] swInstr(input int rs2, input int rs1, input int off);
		return {off[11:5], rs2[4:0], rs1[4:0], 3'b010, off[4:0], OPC_STORE};
	endfunction

	function automatic logic [31:0] branchInstr(input logic [2:0] f3, input int rs1, input int rs2,
			input int off);
		return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3, off[4:1], off[11], OPC_BRANCH};
	endfunction

	function automatic logic [31:0] jalInstr(input int rd, input int off);
		return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
	endfunction

	// arithmetic, a load loop, branches, a write hit, then the halt loop
	task automatic loadProgram(input logic [31:0] base);
		logic [31:0] prog [$];
		mem.delete();
		prog.push_back(luiInstr(1, 'h12345));
		prog.push_back(addiInstr(2, 0, 100));
		prog.push_back(addiInstr(3, 0, -7));
		prog.push_back(arithInstr(1'b0, 4, 1, 2));
		prog.push_back(arithInstr(1'b1, 5, 2, 3));
		prog.push_back(luiInstr(10, 'h2));
		prog.push_back(swInstr(4, 10, 0));
		prog.push_back(swInstr(5, 10, 4));
		prog.push_back(addiInstr(11, 10, 256));
		prog.push_back(addiInstr(12, 0, 5));
		prog.push_back(addiInstr(13, 0, 0));
		prog.push_back(lwInstr(14, 11, 0));
		prog.push_back(arithInstr(1'b0, 13, 13, 14));
		prog.push_back(addiInstr(11, 11, 4));
		prog.push_back(addiInstr(12, 12, -1));
		prog.push_back(branchInstr(F3_BNE, 12, 0, -16));
		prog.push_back(swInstr(13, 10, 8));
		prog.push_back(branchInstr(F3_BEQ, 0, 0, 8));
		prog.push_back(swInstr(1, 10, 12));
		prog.push_back(branchInstr(F3_BEQ, 12, 13, 8));
		prog.push_back(jalInstr(15, 8));
		prog.push_back(swInstr(1, 10, 16));
		prog.push_back(swInstr(3, 10, 20));
		// 0x2104 is still cached from the loop
		prog.push_back(swInstr(2, 10, 260));
		prog.push_back(lwInstr(16, 10, 260));
		prog.push_back(swInstr(16, 10, 24));
		prog.push_back(jalInstr(0, 0));
		foreach (prog[i]) begin
			mem[base + 4 * i] = prog[i];
		end
	endtask

	// direct-mapped tag model, returns 1 on a miss and installs the line
	function automatic logic probeLine(input int side, input logic [31:0] addr);
		logic [31:0] lineNo;
		int idx;
		lineNo = addr / (4 * LINE_WORDS_DEF);
		idx = lineNo % LINES_DEF;
		if (tagValid[side][idx] && tagStore[side][idx] == lineNo / LINES_DEF) begin
			return 1'b0;
		end
		tagValid[side][idx] = 1'b1;
		tagStore[side][idx] = lineNo / LINES_DEF;
		return 1'b1;
	endfunction

	// ISA model, fills the store list and the expected miss counts
	function automatic void runModel(input logic [31:0] boot);
		logic [31:0] regs [REG_COUNT];
		logic [31:0] pc;
		logic [31:0] ins;
		logic [31:0] nextPc;
		logic [31:0] opA;
		logic [31:0] opB;
		logic [31:0] result;
		logic [31:0] addr;
		logic [31:0] iImm;
		logic [31:0] sImm;
		logic [31:0] bImm;
		logic [31:0] jImm;
		logic wb;
		logic done;
		int steps;
		expAddr.delete();
		expData.delete();
		expIMiss = 0;
		expDMiss = 0;
		refMem = mem;
		for (int i = 0; i < REG_COUNT; i++) begin
			regs[i] = '0;
		end
		for (int i = 0; i < LINES_DEF; i++) begin
			tagValid[0][i] = 1'b0;
			tagValid[1][i] = 1'b0;
		end
		pc = boot;
		done = 1'b0;
		steps = 0;
		while (!done && steps < MODEL_STEPS) begin
			if (probeLine(0, pc)) begin
				expIMiss++;
			end
			ins = refRead(pc);
			iImm = {{20{ins[31]}}, ins[31:20]};
			sImm = {{20{ins[31]}}, ins[31:25], ins[11:7]};
			bImm = {{19{ins[31]}}, ins[31], ins[7], ins[30:25], ins[11:8], 1'b0};
			jImm = {{11{ins[31]}}, ins[31], ins[19:12], ins[20], ins[30:21], 1'b0};
			opA = regs[ins[19:15]];
			opB = regs[ins[24:20]];
			result = '0;
			wb = 1'b0;
			nextPc = pc + 4;
			case (ins[6:0])
				OPC_LUI: begin
					result = {ins[31:12], 12'b0};
					wb = 1'b1;
				end
				OPC_OP_IMM: begin
					result = opA + iImm;
					wb = 1'b1;
				end
				OPC_OP: begin
					result = ins[30] ? opA - opB : opA + opB;
					wb = 1'b1;
				end
				OPC_LOAD: begin
					if (probeLine(1, opA + iImm)) begin
						expDMiss++;
					end
					result = refRead(opA + iImm);
					wb = 1'b1;
				end
				OPC_STORE: begin
					// no allocate, so the data tags stay as they are
					addr = opA + sImm;
					expAddr.push_back(addr);
					expData.push_back(opB);
					refMem[addr] = opB;
				end
				OPC_BRANCH: begin
					if ((ins[14:12] == F3_BEQ) == (opA == opB)) begin
						nextPc = pc + bImm;
					end
				end
				OPC_JAL: begin
					if (jImm == '0) begin
						done = 1'b1;
					end else begin
						result = pc + 4;
						wb = 1'b1;
						nextPc = pc + jImm;
					end
				end
				default: ;
			endcase
			if (wb && ins[11:7] != 5'd0) begin
				regs[ins[11:7]] = result;
			end
			if (!done) begin
				pc = nextPc;
			end
			steps++;
		end
		if (!done) begin
			failures++;
			$display("reference model did not reach the halt loop from %h", boot);
		end
	endfunction

	// memory model, answers each strobe after 0 to 7 cycles
	initial begin
		int waitLeft;
		logic [31:0] addr;
		memReady_i = 1'b0;
		memRData_i = '0;
		waitLeft = -1;
		forever begin
			@(negedge clk_mem);
			memReady_i = 1'b0;
			if (memRead_o === 1'b1 || memWrite_o === 1'b1) begin
				if (waitLeft < 0) begin
					waitLeft = drawDelay();
				end
				if (waitLeft == 0) begin
					addr = memAddr_o;
					if (memWrite_o === 1'b1) begin
						mem[addr] = memWData_o;
					end else begin
						memRData_i = mem.exists(addr) ? mem[addr] : fillWord(addr);
					end
					memReady_i = 1'b1;
				end
				waitLeft--;
			end
		end
	end

	// compares every write transfer in order and counts miss pulses
	always @(posedge clk_mem) begin
		if (!rst) begin
			if (memWrite_o === 1'b1 && memReady_i) begin
				if (storeIdx < expAddr.size()) begin
					checkValue("memAddr_o", memAddr_o, expAddr[storeIdx]);
					checkValue("memWData_o", memWData_o, expData[storeIdx]);
				end else begin
					failures++;
					$display("store to %h at %0t was not expected", memAddr_o, $time);
				end
				storeIdx++;
			end
			if (l1iMiss_o === 1'b1) begin
				iMissCnt++;
			end
			if (l1dMiss_o === 1'b1) begin
				dMissCnt++;
			end
		end
	end

	task automatic runProgram(input logic [31:0] boot);
		int waited;
		loadProgram(boot);
		runModel(boot);
		storeIdx = 0;
		iMissCnt = 0;
		dMissCnt = 0;
		@(negedge clk_mem);
		rst = 1'b1;
		enable_i = 1'b0;
		bootPc_i = boot;
		repeat (4) @(negedge clk_mem);
		rst = 1'b0;
		// disabled core stays quiet while the PC takes the boot address
		repeat (6) begin
			@(posedge clk_mem);
			checkValue("memRead_o", 32'(memRead_o), 32'd0);
			checkValue("memWrite_o", 32'(memWrite_o), 32'd0);
			checkValue("l1iMiss_o", 32'(l1iMiss_o), 32'd0);
			checkValue("l1dMiss_o", 32'(l1dMiss_o), 32'd0);
		end
		@(negedge clk_mem);
		enable_i = 1'b1;
		waited = 0;
		while (!(storeIdx >= expAddr.size() && iMissCnt >= expIMiss && dMissCnt >= expDMiss)
				&& waited < RUN_TIMEOUT) begin
			@(negedge clk_mem);
			waited++;
		end
		if (waited >= RUN_TIMEOUT) begin
			failures++;
			$display("timeout in run from %h: %0d of %0d stores, %0d of %0d i-misses, %0d of %0d d-misses",
				boot, storeIdx, expAddr.size(), iMissCnt, expIMiss, dMissCnt, expDMiss);
		end
		// longer than a full refill, so late extra traffic still shows
		repeat (64) @(negedge clk_mem);
		checkValue("store count", storeIdx, expAddr.size());
		checkValue("l1iMiss_o pulses", iMissCnt, expIMiss);
		checkValue("l1dMiss_o pulses", dMissCnt, expDMiss);
	endtask

	initial begin
		rst = 1'b1;
		enable_i = 1'b0;
		bootPc_i = '0;
		runProgram(32'h0000_0100);
		// same program at an unaligned boot address
		runProgram(32'h0000_0a48);
		$display("summary: %0d mismatches, %0d other errors", mismatches, failures);
		if (mismatches == 0 && failures == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: verif/rvSystem_sva.sv
`default_nettype none

module rvSystemSva (
	input wire        clk_mem,
	input wire        rst,
	input wire        memRead_i,
	input wire        memWrite_i,
	input wire [31:0] memAddr_i,
	input wire [31:0] memWData_i,
	input wire        memReady_i,
	input wire        l1iMiss_i,
	input wire        l1dMiss_i
);

	// one direction at a time on the memory port
	strobeExclusive: assert property (@(posedge clk_mem) disable iff (rst)
		!(memRead_i && memWrite_i))
		else $error("memory read and write strobes high together");

	// a waiting strobe keeps its direction until ready
	strobeHold: assert property (@(posedge clk_mem) disable iff (rst)
		(memRead_i || memWrite_i) && !memReady_i |=> $stable({memRead_i, memWrite_i}))
		else $error("memory strobe dropped or changed before ready");

	strobeStable: assert property (@(posedge clk_mem) disable iff (rst)
		(memRead_i || memWrite_i) && !memReady_i |=> $stable(memAddr_i) && $stable(memWData_i))
		else $error("memory address or write data moved while waiting for ready");

	// miss outputs are single-cycle pulses
	iMissPulse: assert property (@(posedge clk_mem) disable iff (rst)
		l1iMiss_i |=> !l1iMiss_i)
		else $error("instruction miss pulse longer than one cycle");

	dMissPulse: assert property (@(posedge clk_mem) disable iff (rst)
		l1dMiss_i |=> !l1dMiss_i)
		else $error("data miss pulse longer than one cycle");

endmodule

bind rvSystem rvSystemSva rvSystemSva_i (
	.clk_mem    (clk_mem),
	.rst        (rst),
	.memRead_i  (memRead_o),
	.memWrite_i (memWrite_o),
	.memAddr_i  (memAddr_o),
	.memWData_i (memWData_o),
	.memReady_i (memReady_i),
	.l1iMiss_i  (l1iMiss_o),
	.l1dMiss_i  (l1dMiss_o)
);

`default_nettype wire

// File: rtl/rvSystem.sv
`default_nettype none

module rvSystem #(
	parameter int lineWords = memPkg::LINE_WORDS_DEF,
	parameter int lines = memPkg::LINES_DEF
) (
	input  wire                       clk_mem,
	input  wire                       rst,
	input  wire                       enable_i,
	input  wire  [31:0]               bootPc_i,
	input  wire  [31:0]               memRData_i,
	input  wire                       memReady_i,
	output logic                      memRead_o,
	output logic                      memWrite_o,
	output logic [memPkg::ADDR_W-1:0] memAddr_o,
	output logic [31:0]               memWData_o,
	output logic                      l1iMiss_o,
	output logic                      l1dMiss_o
);

	coreCacheIf instCoreIf ();
	coreCacheIf dataCoreIf ();
	cacheMemIf instMemIf ();
	cacheMemIf dataMemIf ();

	rvCore rvCore_i (
		.clk_mem  (clk_mem),
		.rst      (rst),
		.enable_i (enable_i),
		.bootPc_i (bootPc_i),
		.imem_o   (instCoreIf.core),
		.dmem_o   (dataCoreIf.core)
	);

	// same cache for both sides, the instruction one never sees a write
	l1Cache #(
		.lineWords (lineWords),
		.lines     (lines)
	) l1ICache_i (
		.clk_mem (clk_mem),
		.rst     (rst),
		.core_i  (instCoreIf.cache),
		.mem_o   (instMemIf.cache),
		.miss_o  (l1iMiss_o)
	);

	l1Cache #(
		.lineWords (lineWords),
		.lines     (lines)
	) l1DCache_i (
		.clk_mem (clk_mem),
		.rst     (rst),
		.core_i  (dataCoreIf.cache),
		.mem_o   (dataMemIf.cache),
		.miss_o  (l1dMiss_o)
	);

	memArbiter memArbiter_i (
		.clk_mem    (clk_mem),
		.rst        (rst),
		.iSide_i    (instMemIf.mem),
		.dSide_i    (dataMemIf.mem),
		.memRead_o  (memRead_o),
		.memWrite_o (memWrite_o),
		.memAddr_o  (memAddr_o),
		.memWData_o (memWData_o),
		.memRData_i (memRData_i),
		.memReady_i (memReady_i)
	);

endmodule

`default_nettype wire

// File: rtl/memArbiter.sv
`default_nettype none

module memArbiter (
	input  wire                        clk_mem,
	input  wire                        rst,
	cacheMemIf.mem                     iSide_i,
	cacheMemIf.mem                     dSide_i,
	output logic                       memRead_o,
	output logic                       memWrite_o,
	output logic [memPkg::ADDR_W-1:0]  memAddr_o,
	output logic [31:0]                memWData_o,
	input  wire  [31:0]                memRData_i,
	input  wire                        memReady_i
);

	logic locked;
	logic ownerD;
	logic ownerReq;
	logic grantD;
	logic active;
	logic grantWe;

	// owner keeps the port while its req stays up, covering a whole refill
	assign ownerReq = ownerD ? dSide_i.req : iSide_i.req;
	// otherwise data side first
	assign grantD = (locked && ownerReq) ? ownerD : dSide_i.req;
	assign active = grantD ? dSide_i.req : iSide_i.req;
	assign grantWe = grantD ? dSide_i.we : iSide_i.we;

	assign memRead_o = active && !grantWe;
	assign memWrite_o = active && grantWe;
	assign memAddr_o = grantD ? dSide_i.addr : iSide_i.addr;
	assign memWData_o = grantD ? dSide_i.wdata : iSide_i.wdata;

	// response goes back to the granted side only
	assign iSide_i.ready = memReady_i && active && !grantD;
	assign dSide_i.ready = memReady_i && active && grantD;
	assign iSide_i.rdata = grantD ? '0 : memRData_i;
	assign dSide_i.rdata = grantD ? memRData_i : '0;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			locked <= 1'b0;
			ownerD <= 1'b0;
		end else begin
			locked <= active;
			ownerD <= grantD;
		end
	end

endmodule

`default_nettype wire

// File: rtl/l1Cache.sv
`default_nettype none

module l1Cache #(
	parameter int lineWords = memPkg::LINE_WORDS_DEF,
	parameter int lines = memPkg::LINES_DEF
) (
	input  wire       clk_mem,
	input  wire       rst,
	coreCacheIf.cache core_i,
	cacheMemIf.cache  mem_o,
	output logic      miss_o
);
	import memPkg::*;

	localparam int OFF_W = $clog2(lineWords);
	localparam int IDX_W = $clog2(lines);
	localparam int TAG_LSB = 2 + OFF_W + IDX_W;
	localparam int TAG_W = ADDR_W - TAG_LSB;

	cacheStateE state;
	logic [TAG_W-1:0] tagArr [lines];
	logic [31:0] dataArr [lines][lineWords];
	logic [lines-1:0] validArr;
	logic [OFF_W-1:0] fillCnt;
	logic [TAG_W-1:0] reqTag;
	logic [IDX_W-1:0] reqIdx;
	logic [OFF_W-1:0] reqOff;
	logic hit;

	// address split into tag, line index and word offset
	assign reqTag = core_i.addr[ADDR_W-1:TAG_LSB];
	assign reqIdx = core_i.addr[TAG_LSB-1:2+OFF_W];
	assign reqOff = core_i.addr[2+OFF_W-1:2];
	assign hit = validArr[reqIdx] && (tagArr[reqIdx] == reqTag);

	assign core_i.rdata = dataArr[reqIdx][reqOff];
	assign miss_o = (state == IDLE) && core_i.read && !hit;

	always_comb begin
		case (state)
			IDLE: core_i.stall = core_i.write || (core_i.read && !hit);
			FILL: core_i.stall = 1'b1;
			// released in the ready cycle so the core retires the store there
			STORE: core_i.stall = !mem_o.ready;
			default: core_i.stall = 1'b1;
		endcase
	end

	// refill walks the line from word 0
	assign mem_o.req = (state != IDLE);
	assign mem_o.we = (state == STORE);
	assign mem_o.addr = (state == FILL) ? {reqTag, reqIdx, fillCnt, 2'b00} : core_i.addr;
	assign mem_o.wdata = core_i.wdata;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			state <= IDLE;
			fillCnt <= '0;
			validArr <= '0;
		end else begin
			case (state)
				IDLE: begin
					fillCnt <= '0;
					if (core_i.write) begin
						state <= STORE;
					end else if (miss_o) begin
						validArr[reqIdx] <= 1'b0;
						state <= FILL;
					end
				end
				FILL: begin
					if (mem_o.ready) begin
						fillCnt <= fillCnt + 1'b1;
						if (fillCnt == OFF_W'(lineWords - 1)) begin
							validArr[reqIdx] <= 1'b1;
							state <= IDLE;
						end
					end
				end
				STORE: begin
					if (mem_o.ready) begin
						state <= IDLE;
					end
				end
				default: state <= IDLE;
			endcase
		end
	end

	// tag and data arrays
	always_ff @(posedge clk_mem) begin
		if (state == FILL && mem_o.ready) begin
			dataArr[reqIdx][fillCnt] <= mem_o.rdata;
			tagArr[reqIdx] <= reqTag;
		end else if (state == STORE && mem_o.ready && hit) begin
			// no write allocate, a miss leaves the array untouched
			dataArr[reqIdx][reqOff] <= core_i.wdata;
		end
	end

endmodule

`default_nettype wire

// File: rtl/rvCore.sv
`default_nettype none

module rvCore (
	input  wire        clk_mem,
	input  wire        rst,
	input  wire        enable_i,
	input  wire [31:0] bootPc_i,
	coreCacheIf.core   imem_o,
	coreCacheIf.core   dmem_o
);
	import cpuPkg::*;

	logic [31:0] pc;
	logic [31:0] pcPlus4;
	logic [31:0] nextPc;
	logic [31:0] instr;
	logic [31:0] imm;
	logic [31:0] rs1Val;
	logic [31:0] rs2Val;
	logic [31:0] aluB;
	logic [31:0] aluOut;
	logic [31:0] wbData;
	logic [31:0] regFile [REG_COUNT];
	logic [REG_IDX_W-1:0] rs1Idx;
	logic [REG_IDX_W-1:0] rs2Idx;
	logic [REG_IDX_W-1:0] rdIdx;
	logic [2:0] funct3;
	opcodeE opcode;
	aluOpE aluOp;
	logic useImm;
	logic regWrite;
	logic isLoad;
	logic isStore;
	logic isBranch;
	logic isJal;
	logic brTaken;
	logic advance;

	assign instr = imem_o.rdata;
	assign opcode = opcodeE'(instr[6:0]);
	assign rdIdx = instr[11:7];
	assign funct3 = instr[14:12];
	assign rs1Idx = instr[19:15];
	assign rs2Idx = instr[24:20];

	// decoder, unknown opcodes fall through as a nop
	always_comb begin
		imm = '0;
		aluOp = ALU_ADD;
		useImm = 1'b0;
		regWrite = 1'b0;
		isLoad = 1'b0;
		isStore = 1'b0;
		isBranch = 1'b0;
		isJal = 1'b0;
		case (opcode)
			OPC_LUI: begin
				imm = {instr[31:12], 12'b0};
				aluOp = ALU_PASSB;
				useImm = 1'b1;
				regWrite = 1'b1;
			end
			OPC_OP_IMM, OPC_LOAD: begin
				imm = {{20{instr[31]}}, instr[31:20]};
				useImm = 1'b1;
				regWrite = 1'b1;
				isLoad = (opcode == OPC_LOAD);
			end
			OPC_OP: begin
				aluOp = instr[30] ? ALU_SUB : ALU_ADD;
				regWrite = 1'b1;
			end
			OPC_STORE: begin
				imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
				useImm = 1'b1;
				isStore = 1'b1;
			end
			OPC_BRANCH: begin
				imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
				isBranch = 1'b1;
			end
			OPC_JAL: begin
				imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
				regWrite = 1'b1;
				isJal = 1'b1;
			end
			default: ;
		endcase
	end

	// x0 is never written, so it reads back as zero
	assign rs1Val = regFile[rs1Idx];
	assign rs2Val = regFile[rs2Idx];
	assign aluB = useImm ? imm : rs2Val;

	always_comb begin
		case (aluOp)
			ALU_SUB: aluOut = rs1Val - aluB;
			ALU_PASSB: aluOut = aluB;
			default: aluOut = rs1Val + aluB;
		endcase
	end

	// beq and bne only
	assign brTaken = isBranch && ((funct3 == F3_BEQ && rs1Val == rs2Val)
		|| (funct3 == F3_BNE && rs1Val != rs2Val));
	assign pcPlus4 = pc + 32'd4;
	assign nextPc = (isJal || brTaken) ? pc + imm : pcPlus4;
	assign wbData = isLoad ? dmem_o.rdata : (isJal ? pcPlus4 : aluOut);

	// data side only sees a request once the fetched word is valid
	assign imem_o.read = enable_i;
	assign imem_o.write = 1'b0;
	assign imem_o.addr = pc;
	assign imem_o.wdata = '0;
	assign dmem_o.read = enable_i && !imem_o.stall && isLoad;
	assign dmem_o.write = enable_i && !imem_o.stall && isStore;
	assign dmem_o.addr = aluOut;
	assign dmem_o.wdata = rs2Val;

	assign advance = enable_i && !imem_o.stall && !dmem_o.stall;

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			pc <= '0;
		end else if (!enable_i) begin
			pc <= bootPc_i;
		end else if (advance) begin
			pc <= nextPc;
		end
	end

	always_ff @(posedge clk_mem) begin
		if (rst) begin
			for (int i = 0; i < REG_COUNT; i++) begin
				regFile[i] <= '0;
			end
		end else if (advance && regWrite && rdIdx != '0) begin
			regFile[rdIdx] <= wbData;
		end
	end

endmodule

`default_nettype wire

// File: rtl/memIfs.sv
`default_nettype none

// core to L1 cache, request held as a level until stall is low
interface coreCacheIf;
	import memPkg::*;

	logic              read;
	logic              write;
	logic [ADDR_W-1:0] addr;
	logic [31:0]       wdata;
	logic [31:0]       rdata;
	logic              stall;

	modport core (output read, write, addr, wdata, input rdata, stall);
	modport cache (input read, write, addr, wdata, output rdata, stall);
endinterface

// L1 cache to memory, req held until a one-cycle ready
interface cacheMemIf;
	import memPkg::*;

	logic              req;
	logic              we;
	logic [ADDR_W-1:0] addr;
	logic [31:0]       wdata;
	logic [31:0]       rdata;
	logic              ready;

	modport cache (output req, we, addr, wdata, input rdata, ready);
	modport mem (input req, we, addr, wdata, output rdata, ready);
endinterface

`default_nettype wire

// File: rtl/memPkg.sv
`default_nettype none

package memPkg;

	// byte address width on every bus
	localparam int ADDR_W = 32;

	// default L1 geometry, same for both caches
	localparam int LINE_WORDS_DEF = 4;
	localparam int LINES_DEF = 16;

	// cache controller states
	// fill walks the line one word per transfer
	// store waits for the single write-through transfer
	typedef enum logic [1:0] {
		IDLE,
		FILL,
		STORE
	} cacheStateE;

endpackage

`default_nettype wire

// File: rtl/cpuPkg.sv
`default_nettype none

package cpuPkg;

	// architectural register count, x0 included
	localparam int REG_COUNT = 32;
	localparam int REG_IDX_W = $clog2(REG_COUNT);

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_OP_IMM = 7'b0010011,
		OPC_OP     = 7'b0110011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_BRANCH = 7'b1100011,
		OPC_JAL    = 7'b1101111
	} opcodeE;

	// ALU operations
	// passb forwards operand b, used by LUI
	typedef enum logic [1:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_PASSB
	} aluOpE;

	// funct3 values that tell the two branches apart
	localparam logic [2:0] F3_BEQ = 3'b000;
	localparam logic [2:0] F3_BNE = 3'b001;

endpackage

`default_nettype wire
